//--- include/lb_slave_config.svh
//--------------------------------------------------------------------------
// Local-bus slave build constants
// LED counter width, configuration default and identification words
//--------------------------------------------------------------------------

`ifndef LB_SLAVE_CONFIG_SVH
`define LB_SLAVE_CONFIG_SVH

// LED counter width
// PWM period and uptime step are both 2**LED_CW cycles
`define LED_CW 10

// Miscellaneous configuration after reset
`define MISC_CONFIG_DEFAULT 8'h0c

// Identification string "Hello world!(::)", four ASCII words
`define ID_WORD_0 32'h48656c6c
`define ID_WORD_1 32'h6f20776f
`define ID_WORD_2 32'h726c6421
`define ID_WORD_3 32'h283a3a29

`endif

//--- verilog/lb_bus_pkg.sv
//--------------------------------------------------------------------------
// Local-bus types
// Address, data word and region selector of the host bus
//--------------------------------------------------------------------------

package lb_bus_pkg;

	// Full host address
	typedef logic [23:0] lb_addr_t;

	// Read and write data word
	typedef logic [31:0] lb_data_t;

	// Upper address byte, picks the region
	typedef logic [7:0] lb_region_t;

endpackage

//--- verilog/lb_regs_pkg.sv
//--------------------------------------------------------------------------
// Register content types
// Widths of the LED, counter, configuration and mirror fields
//--------------------------------------------------------------------------

package lb_regs_pkg;

	// LED duty factor, scaled by four against the LED counter
	typedef logic [7:0] pwm_duty_t;

	// Packet category and per-category count
	typedef logic [3:0] pkt_cat_t;
	typedef logic [19:0] pkt_count_t;

	// Miscellaneous configuration byte
	typedef logic [7:0] misc_cfg_t;

	// Word address into the write mirror
	typedef logic [4:0] mirror_addr_t;

	// Cross-domain fault count
	typedef logic [15:0] fault_count_t;

endpackage

//--- verilog/lb_pkt_counters.sv
`timescale 1ns/100ps
//--------------------------------------------------------------------------
// Packet-category counters
// One wrapping counter per category, a shared clear and a registered read
//--------------------------------------------------------------------------

module lb_pkt_counters (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    inc,
	input  lb_regs_pkg::pkt_cat_t   inc_cat,
	input  logic                    clear,
	input  lb_regs_pkg::pkt_cat_t   read_cat,
	output lb_regs_pkg::pkt_count_t read_data
);
	import lb_regs_pkg::*;

	localparam int NCAT = 2 ** $bits(pkt_cat_t);

	pkt_count_t count [NCAT];

	// Clear has priority over a count in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NCAT; i++) begin
				count[i] <= '0;
			end
		end else if (clear) begin
			for (int i = 0; i < NCAT; i++) begin
				count[i] <= '0;
			end
		end else if (inc) begin
			count[inc_cat] <= count[inc_cat] + 1'b1;
		end
	end

	// Read port, lines up with read stage one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_data <= '0;
		end else begin
			read_data <= count[read_cat];
		end
	end

endmodule

//--- verilog/lb_mirror_ram.sv
`timescale 1ns/100ps
//--------------------------------------------------------------------------
// Write mirror memory
// Simple dual-port RAM, one word per local register, registered read
//--------------------------------------------------------------------------

module lb_mirror_ram (
	input  logic                      clk,
	input  logic                      wen,
	input  lb_regs_pkg::mirror_addr_t waddr,
	input  lb_bus_pkg::lb_data_t      wdata,
	input  lb_regs_pkg::mirror_addr_t raddr,
	output lb_bus_pkg::lb_data_t      rdata
);
	import lb_bus_pkg::*;
	import lb_regs_pkg::*;

	localparam int DEPTH = 2 ** $bits(mirror_addr_t);

	lb_data_t mem [DEPTH];

	// Read before write on a shared address
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

//--- verilog/lb_led_pwm.sv
`timescale 1ns/100ps
//--------------------------------------------------------------------------
// LED PWM
// Free-running counter, two duty comparators and a once-per-period tick
//--------------------------------------------------------------------------

`include "lb_slave_config.svh"

module lb_led_pwm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lb_regs_pkg::pwm_duty_t duty_1,
	input  lb_regs_pkg::pwm_duty_t duty_2,
	output logic                   led1,
	output logic                   led2,
	output logic                   tick
);

	logic [`LED_CW-1:0] led_cc;
	logic               wrap;

	// Counter sits at all ones in the last cycle of a period
	assign wrap = &led_cc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cc <= '0;
			tick   <= 1'b0;
		end else begin
			led_cc <= led_cc + 1'b1;
			tick   <= wrap;
		end
	end

	//----------------------------------------------------------------------
	// Comparators
	//----------------------------------------------------------------------

	// High for four times the duty counts per period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {duty_1, 2'b00};
			led2 <= led_cc < {duty_2, 2'b00};
		end
	end

endmodule

//--- verilog/lb_marble_slave.sv
`timescale 1ns/100ps
//--------------------------------------------------------------------------
// Local-bus register slave
// Status bank, packet counters, write mirror and LED registers behind
// a fixed two-cycle read pipeline
//--------------------------------------------------------------------------

`include "lb_slave_config.svh"

module lb_marble_slave (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lb_bus_pkg::lb_addr_t   addr,
	input  logic                   control_strobe,
	input  logic                   control_rd,
	input  lb_bus_pkg::lb_data_t   data_out,
	output lb_bus_pkg::lb_data_t   data_in,
	input  logic                   xdomain_fault,
	input  logic                   pkt_inc,
	input  lb_regs_pkg::pkt_cat_t  pkt_cat,
	input  logic [1:0]             rx_buf_status,
	output logic [1:0]             led_user_mode,
	output logic                   led1,
	output logic                   led2,
	output lb_regs_pkg::misc_cfg_t cfg_out
);
	import lb_bus_pkg::*;
	import lb_regs_pkg::*;

	localparam lb_region_t REGION_BANK  = 8'h00;
	localparam lb_region_t REGION_COUNT = 8'h04;
	localparam lb_region_t REGION_LOCAL = 8'h05;

	logic         do_rd;
	logic         local_write;
	mirror_addr_t reg_sel;

	logic [1:0]   led_user_r;
	pwm_duty_t    led_1_df;
	pwm_duty_t    led_2_df;
	misc_cfg_t    misc_cfg;
	logic         cnt_clear;

	fault_count_t fault_count;
	lb_data_t     uptime;
	logic         led_tick;
	logic [1:0]   rx_status_r;

	logic         do_rd_r;
	lb_addr_t     addr_r;
	lb_region_t   region_r;
	lb_data_t     bank_word;
	pkt_count_t   pkt_count;
	lb_data_t     mirror_word;

	assign do_rd       = control_strobe & control_rd;
	assign local_write = control_strobe & ~control_rd & (addr[23:16] == REGION_LOCAL);
	assign reg_sel     = addr[4:0];

	//----------------------------------------------------------------------
	// Local writes
	//----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user_r <= '0;
			led_1_df   <= '0;
			led_2_df   <= '0;
			misc_cfg   <= `MISC_CONFIG_DEFAULT;
		end else if (local_write) begin
			case (reg_sel)
				5'd1: led_user_r <= data_out[1:0];
				5'd2: led_1_df   <= data_out[7:0];
				5'd3: led_2_df   <= data_out[7:0];
				5'd8: misc_cfg   <= data_out[7:0];
				default: ;
			endcase
		end
	end

	// Counter clear, one cycle after the write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_clear <= 1'b0;
		end else begin
			cnt_clear <= local_write & (reg_sel == 5'd4);
		end
	end

	assign led_user_mode = led_user_r;
	assign cfg_out       = misc_cfg;

	//----------------------------------------------------------------------
	// Status sources
	//----------------------------------------------------------------------

	// Uptime steps once per LED period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_count <= '0;
			uptime      <= '0;
			rx_status_r <= '0;
		end else begin
			if (xdomain_fault) begin
				fault_count <= fault_count + 1'b1;
			end
			if (led_tick) begin
				uptime <= uptime + 1'b1;
			end
			rx_status_r <= rx_buf_status;
		end
	end

	lb_pkt_counters u_pkt_counters (
		.clk       (clk),
		.rst_n     (rst_n),
		.inc       (pkt_inc),
		.inc_cat   (pkt_cat),
		.clear     (cnt_clear),
		.read_cat  (addr[3:0]),
		.read_data (pkt_count)
	);

	// Every local write lands in the mirror as well
	lb_mirror_ram u_mirror_ram (
		.clk   (clk),
		.wen   (local_write),
		.waddr (reg_sel),
		.wdata (data_out),
		.raddr (reg_sel),
		.rdata (mirror_word)
	);

	lb_led_pwm u_led_pwm (
		.clk    (clk),
		.rst_n  (rst_n),
		.duty_1 (led_1_df),
		.duty_2 (led_2_df),
		.led1   (led1),
		.led2   (led2),
		.tick   (led_tick)
	);

	//----------------------------------------------------------------------
	// Read stage one
	//----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= addr;
		if (do_rd) begin
			case (addr[3:0])
				4'h0: bank_word <= `ID_WORD_0;
				4'h1: bank_word <= `ID_WORD_1;
				4'h2: bank_word <= `ID_WORD_2;
				4'h3: bank_word <= `ID_WORD_3;
				4'h4: bank_word <= lb_data_t'(fault_count);
				4'h5: bank_word <= uptime;
				4'h6: bank_word <= lb_data_t'(rx_status_r);
				4'h7: bank_word <= lb_data_t'(misc_cfg);
				// "zzzz" marks an unused bank slot
				default: bank_word <= 32'h7a7a7a7a;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Read stage two
	//----------------------------------------------------------------------

	assign region_r = addr_r[23:16];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			if (region_r == REGION_BANK && addr_r[7:4] == 4'h0) begin
				data_in <= bank_word;
			end else if (region_r == REGION_COUNT && addr_r[15:12] == 4'h1) begin
				data_in <= lb_data_t'(pkt_count);
			end else if (region_r == REGION_LOCAL) begin
				data_in <= mirror_word;
			end else begin
				data_in <= 32'hdeadbeef;
			end
		end
	end

endmodule

//--- verilog/lb_subsys_top.sv
`timescale 1ns/100ps
//--------------------------------------------------------------------------
// Local-bus subsystem top
// Wraps the register slave behind a fixed port boundary
//--------------------------------------------------------------------------

module lb_subsys_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lb_bus_pkg::lb_addr_t   addr,
	input  logic                   control_strobe,
	input  logic                   control_rd,
	input  lb_bus_pkg::lb_data_t   data_out,
	output lb_bus_pkg::lb_data_t   data_in,
	input  logic                   xdomain_fault,
	input  logic                   pkt_inc,
	input  lb_regs_pkg::pkt_cat_t  pkt_cat,
	input  logic [1:0]             rx_buf_status,
	output logic [1:0]             led_user_mode,
	output logic                   led1,
	output logic                   led2,
	output lb_regs_pkg::misc_cfg_t cfg_out
);

	lb_marble_slave u_slave (
		.clk            (clk),
		.rst_n          (rst_n),
		.addr           (addr),
		.control_strobe (control_strobe),
		.control_rd     (control_rd),
		.data_out       (data_out),
		.data_in        (data_in),
		.xdomain_fault  (xdomain_fault),
		.pkt_inc        (pkt_inc),
		.pkt_cat        (pkt_cat),
		.rx_buf_status  (rx_buf_status),
		.led_user_mode  (led_user_mode),
		.led1           (led1),
		.led2           (led2),
		.cfg_out        (cfg_out)
	);

endmodule

//--- sim/lb_subsys_tb.sv
`timescale 1ns/100ps
//--------------------------------------------------------------------------
// Local-bus subsystem testbench
// Shadow model of the slave, queued read checks and LED duty counts
//--------------------------------------------------------------------------

`include "lb_slave_config.svh"

module lb_subsys_tb;
	import lb_bus_pkg::*;
	import lb_regs_pkg::*;

	localparam int LED_PERIOD = 2 ** `LED_CW;
	localparam int WAIT_LIMIT = 16;

	logic       clk;
	logic       rst_n;
	lb_addr_t   addr;
	logic       control_strobe;
	logic       control_rd;
	lb_data_t   data_out;
	lb_data_t   data_in;
	logic       xdomain_fault;
	logic       pkt_inc;
	pkt_cat_t   pkt_cat;
	logic [1:0] rx_buf_status;
	logic [1:0] led_user_mode;
	logic       led1;
	logic       led2;
	misc_cfg_t  cfg_out;

	// Shadow model
	pkt_count_t   sh_count [16];
	lb_data_t     sh_mirror [32];
	logic [1:0]   sh_led_user;
	misc_cfg_t    sh_cfg;
	fault_count_t sh_fault;

	lb_data_t   exp_q [$];
	bit         chk_q [$];
	lb_data_t   exp_word;
	bit         exp_chk;
	lb_data_t   last_read;
	int         reads_done;
	logic [1:0] rd_pipe;
	int         errors;
	int         checks;
	int         seed;

	lb_subsys_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic lb_data_t ref_read(input lb_addr_t a);
		if (a[23:16] == 8'h00 && a[7:4] == 4'h0) begin
			case (a[3:0])
				4'h0: return `ID_WORD_0;
				4'h1: return `ID_WORD_1;
				4'h2: return `ID_WORD_2;
				4'h3: return `ID_WORD_3;
				4'h4: return {16'h0, sh_fault};
				// Uptime depends on the LED phase, checked by its increase
				4'h5: return 32'h0;
				4'h6: return {30'h0, rx_buf_status};
				4'h7: return {24'h0, sh_cfg};
				default: return 32'h7a7a7a7a;
			endcase
		end else if (a[23:16] == 8'h04 && a[15:12] == 4'h1) begin
			return {12'h0, sh_count[a[3:0]]};
		end else if (a[23:16] == 8'h05) begin
			return sh_mirror[a[4:0]];
		end
		return 32'hdeadbeef;
	endfunction

	task automatic report_mismatch(input string name, input lb_data_t expected,
			input lb_data_t actual);
		errors++;
		$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic finish_run;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	task automatic abort_run(input string why);
		errors++;
		$display("Timeout: %s", why);
		finish_run();
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	// One strobe, called 2 ns after a rising edge
	task automatic bus_cycle(input bit rd, input lb_addr_t a, input lb_data_t d);
		addr           = a;
		control_rd     = rd;
		data_out       = d;
		control_strobe = 1'b1;
		idle(1);
		control_strobe = 1'b0;
	endtask

	task automatic local_write(input mirror_addr_t a, input lb_data_t d);
		sh_mirror[a] = d;
		case (a)
			5'd1: sh_led_user = d[1:0];
			5'd8: sh_cfg = d[7:0];
			5'd4: begin
				for (int i = 0; i < 16; i++) begin
					sh_count[i] = '0;
				end
			end
			default: ;
		endcase
		bus_cycle(1'b0, {8'h05, 11'd0, a}, d);
	endtask

	task automatic read_check(input lb_addr_t a);
		exp_q.push_back(ref_read(a));
		chk_q.push_back(1'b1);
		bus_cycle(1'b1, a, '0);
	endtask

	task automatic drain_reads;
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			idle(1);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			abort_run("read results did not arrive");
		end
	endtask

	task automatic read_capture(input lb_addr_t a, output lb_data_t value);
		int start;
		int n;
		drain_reads();
		start = reads_done;
		n = 0;
		exp_q.push_back('0);
		chk_q.push_back(1'b0);
		bus_cycle(1'b1, a, '0);
		while (reads_done == start && n < WAIT_LIMIT) begin
			idle(1);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			abort_run("captured read did not complete");
		end else begin
			value = last_read;
		end
	endtask

	//----------------------------------------------------------------------
	// Read comparison, two cycles after each strobe
	//----------------------------------------------------------------------

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[0], control_strobe & control_rd};
		end
	end

	always @(negedge clk) begin
		if (rd_pipe[1]) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Read result at %0t arrived with nothing expected", $time);
			end else begin
				exp_word  = exp_q.pop_front();
				exp_chk   = chk_q.pop_front();
				last_read = data_in;
				reads_done++;
				if (exp_chk) begin
					checks++;
					if (data_in !== exp_word) begin
						report_mismatch("data_in", exp_word, data_in);
					end
				end
			end
		end
	end

	//----------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------

	initial begin
		int       k;
		int       n1;
		int       n2;
		pwm_duty_t d1;
		pwm_duty_t d2;
		lb_data_t u0;
		lb_data_t u1;
		seed           = $urandom(32'hc246);
		rst_n          = 1'b0;
		addr           = '0;
		control_strobe = 1'b0;
		control_rd     = 1'b0;
		data_out       = '0;
		xdomain_fault  = 1'b0;
		pkt_inc        = 1'b0;
		pkt_cat        = '0;
		// Nonzero so the status readback is visible
		rx_buf_status  = 2'(1 + $urandom % 3);
		errors         = 0;
		checks         = 0;
		reads_done     = 0;
		sh_led_user    = '0;
		sh_cfg         = `MISC_CONFIG_DEFAULT;
		sh_fault       = '0;
		for (int i = 0; i < 16; i++) begin
			sh_count[i] = '0;
		end
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;

		// Reset values and fixed read map
		checks += 5;
		if (led1 !== 1'b0) report_mismatch("led1", 0, led1);
		if (led2 !== 1'b0) report_mismatch("led2", 0, led2);
		if (led_user_mode !== 2'b00) report_mismatch("led_user_mode", 0, led_user_mode);
		if (cfg_out !== `MISC_CONFIG_DEFAULT) report_mismatch("cfg_out", sh_cfg, cfg_out);
		if (data_in !== '0) report_mismatch("data_in", 0, data_in);
		for (int i = 0; i < 16; i++) begin
			if (i != 5) read_check(24'(i));
		end
		read_check(24'h000010);
		read_check(24'h040003);
		read_check(24'h123456);

		// Mirror writes, then the written words read back to back
		for (int i = 0; i < 32; i++) begin
			local_write(5'(i), $urandom);
			read_check({8'h05, 11'd0, 5'(i)});
		end
		repeat (40) begin
			k = $urandom % 32;
			local_write(5'(k), $urandom);
		end
		for (int i = 0; i < 32; i++) begin
			read_check({8'h05, 11'd0, 5'(i)});
		end
		// New values always differ from the current ones
		local_write(5'd1, {30'($urandom), ~sh_led_user});
		local_write(5'd8, {24'($urandom), ~sh_cfg});
		checks += 2;
		if (led_user_mode !== sh_led_user) begin
			report_mismatch("led_user_mode", sh_led_user, led_user_mode);
		end
		if (cfg_out !== sh_cfg) report_mismatch("cfg_out", sh_cfg, cfg_out);
		read_check(24'h000007);

		// Packet counters and their clear
		repeat (300) begin
			pkt_cat = 4'($urandom);
			pkt_inc = 1'($urandom);
			if (pkt_inc) sh_count[pkt_cat] = sh_count[pkt_cat] + 1'b1;
			idle(1);
		end
		pkt_inc = 1'b0;
		idle(1);
		for (int c = 0; c < 16; c++) begin
			read_check({8'h04, 4'h1, 8'h00, 4'(c)});
		end
		local_write(5'd4, '0);
		idle(1);
		for (int c = 0; c < 16; c++) begin
			read_check({8'h04, 4'h1, 8'h00, 4'(c)});
		end

		// Fault counter
		k = 5 + $urandom % 20;
		sh_fault = sh_fault + 16'(k);
		xdomain_fault = 1'b1;
		idle(k);
		xdomain_fault = 1'b0;
		read_check(24'h000004);

		// LED duty counts over one full period
		repeat (3) begin
			d1 = 8'($urandom);
			d2 = 8'($urandom);
			local_write(5'd2, {24'h0, d1});
			local_write(5'd3, {24'h0, d2});
			idle(2);
			n1 = 0;
			n2 = 0;
			repeat (LED_PERIOD) begin
				@(negedge clk);
				n1 += led1;
				n2 += led2;
			end
			idle(1);
			checks += 2;
			if (n1 != 4 * d1) report_mismatch("led1 high cycles", 4 * d1, n1);
			if (n2 != 4 * d2) report_mismatch("led2 high cycles", 4 * d2, n2);
		end

		// Uptime advances across one LED period
		read_capture(24'h000005, u0);
		idle(LED_PERIOD);
		read_capture(24'h000005, u1);
		checks++;
		if (u1 - u0 < 1) begin
			errors++;
			$display("Uptime did not advance over one LED period (%h to %h)", u0, u1);
		end
		drain_reads();
		finish_run();
	end

endmodule

//--- lb_subsys.f
+incdir+include
verilog/lb_bus_pkg.sv
verilog/lb_regs_pkg.sv
verilog/lb_pkt_counters.sv
verilog/lb_mirror_ram.sv
verilog/lb_led_pwm.sv
verilog/lb_marble_slave.sv
verilog/lb_subsys_top.sv
sim/lb_subsys_tb.sv

//--- Bender.yml
package:
  name: lb_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/lb_bus_pkg.sv
      - verilog/lb_regs_pkg.sv
      - verilog/lb_pkt_counters.sv
      - verilog/lb_mirror_ram.sv
      - verilog/lb_led_pwm.sv
      - verilog/lb_marble_slave.sv
      - verilog/lb_subsys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/lb_subsys_tb.sv
